/* list.f */
+incdir+verif
rtl/mrw_pkg.sv
rtl/mrw_sram_1r1w.sv
rtl/mrw_word_align.sv
rtl/mrw_dup_ctrl.sv
rtl/mrw_top.sv
verif/tb_mrw_top.sv

/* rtl/mrw_dup_ctrl.sv */
`timescale 1ns/1ns

module mrw_dup_ctrl
  import mrw_pkg::*;
(
  input  logic              wr_clk,
  input  logic              rst_n,
  input  wr_cmd_t           wr_cmd,
  input  rd_cmd_t           rd_cmd       [NUM_RD_PORTS],
  output bank_wr_t          bank_wr      [NUM_RD_PORTS][NUM_VBANKS],
  output bank_rd_t          bank_rd      [NUM_RD_PORTS][NUM_VBANKS],
  input  logic [DATA_W-1:0] bank_rd_word [NUM_RD_PORTS][NUM_VBANKS],
  output logic [NUM_RD_PORTS-1:0] rd_vld,
  output logic [DATA_W-1:0] rd_dout      [NUM_RD_PORTS]
);

  mrw_adr_u           wr_adr;
  mrw_adr_u           rd_adr    [NUM_RD_PORTS];

  // per port tracking of reads in flight through the sram
  logic [SRAM_DELAY-1:0] vld_pipe  [NUM_RD_PORTS];
  logic [VBANK_W-1:0]    bank_pipe [NUM_RD_PORTS][SRAM_DELAY];
  logic [DATA_W-1:0]     ret_word  [NUM_RD_PORTS];

  //////////////////////////////////////////////////////////////////////
  // command decode
  //////////////////////////////////////////////////////////////////////

  assign wr_adr.flat = wr_cmd.adr;

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_adr[p].flat = rd_cmd[p].adr;
    end
  end

  // every copy sees the same write, only the addressed bank is strobed
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      for (int b = 0; b < NUM_VBANKS; b++) begin
        bank_wr[p][b].write = wr_cmd.write && (wr_adr.f.bank == VBANK_W'(b));
        bank_wr[p][b].row   = {wr_adr.f.srow, wr_adr.f.word};
        bank_wr[p][b].bw    = wr_cmd.bw;
        bank_wr[p][b].din   = wr_cmd.din;
      end
    end
  end

  // reads stay inside their own port's copy
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      for (int b = 0; b < NUM_VBANKS; b++) begin
        bank_rd[p][b].read = rd_cmd[p].read && (rd_adr[p].f.bank == VBANK_W'(b));
        bank_rd[p][b].row  = {rd_adr[p].f.srow, rd_adr[p].f.word};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read return
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        vld_pipe[p] <= '0;
        for (int s = 0; s < SRAM_DELAY; s++) begin
          bank_pipe[p][s] <= '0;
        end
      end
    end else begin
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        vld_pipe[p][0]  <= rd_cmd[p].read;
        bank_pipe[p][0] <= rd_adr[p].f.bank;
        for (int s = 1; s < SRAM_DELAY; s++) begin
          vld_pipe[p][s]  <= vld_pipe[p][s-1];
          bank_pipe[p][s] <= bank_pipe[p][s-1];
        end
      end
    end
  end

  // pick the bank that was addressed SRAM_DELAY cycles ago
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      ret_word[p] = bank_rd_word[p][0];
      for (int b = 1; b < NUM_VBANKS; b++) begin
        if (bank_pipe[p][SRAM_DELAY-1] == VBANK_W'(b)) begin
          ret_word[p] = bank_rd_word[p][b];
        end
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      rd_vld <= '0;
    end else begin
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        rd_vld[p] <= vld_pipe[p][SRAM_DELAY-1];
      end
    end
  end

  // data holds between reads
  always_ff @(posedge wr_clk) begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      if (vld_pipe[p][SRAM_DELAY-1]) begin
        rd_dout[p] <= ret_word[p];
      end
    end
  end

endmodule

/* rtl/mrw_pkg.sv */
package mrw_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int DATA_W       = 16;
  localparam int ADDR_W       = 8;
  localparam int NUM_ADDR     = 256;
  localparam int NUM_RD_PORTS = 2;

  // banks inside one copy
  localparam int NUM_VBANKS   = 2;
  localparam int VBANK_W      = 1;
  localparam int VROW_W       = 7;

  // words folded into one physical row
  localparam int NUM_WORDS    = 2;
  localparam int WORD_W       = 1;
  localparam int SROW_W       = 6;
  localparam int PHY_W        = NUM_WORDS * DATA_W;

  // sram read latency, plus one output register in the controller
  localparam int SRAM_DELAY   = 2;
  localparam int RD_LATENCY   = SRAM_DELAY + 1;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [SROW_W-1:0]  srow;
    logic [WORD_W-1:0]  word;
    logic [VBANK_W-1:0] bank;
  } mrw_adr_f_t;

  typedef union packed {
    logic [ADDR_W-1:0] flat;
    mrw_adr_f_t        f;
  } mrw_adr_u;

  //////////////////////////////////////////////////////////////////////
  // command structs
  //////////////////////////////////////////////////////////////////////

  // logical side
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] bw;
    logic [DATA_W-1:0] din;
  } wr_cmd_t;

  typedef struct packed {
    logic              read;
    logic [ADDR_W-1:0] adr;
  } rd_cmd_t;

  // bank side, one word per row
  typedef struct packed {
    logic              write;
    logic [VROW_W-1:0] row;
    logic [DATA_W-1:0] bw;
    logic [DATA_W-1:0] din;
  } bank_wr_t;

  typedef struct packed {
    logic              read;
    logic [VROW_W-1:0] row;
  } bank_rd_t;

  // physical side, full sram row
  typedef struct packed {
    logic              write;
    logic [SROW_W-1:0] adr;
    logic [PHY_W-1:0]  bw;
    logic [PHY_W-1:0]  din;
  } phy_wr_t;

  typedef struct packed {
    logic              read;
    logic [SROW_W-1:0] adr;
  } phy_rd_t;

endpackage

/* rtl/mrw_sram_1r1w.sv */
`timescale 1ns/1ns

module mrw_sram_1r1w
  import mrw_pkg::*;
(
  input  logic             wr_clk,
  input  phy_wr_t          phy_wr,
  input  phy_rd_t          phy_rd,
  output logic [PHY_W-1:0] rd_data
);

  logic [PHY_W-1:0] mem     [1 << SROW_W];
  logic [PHY_W-1:0] rd_pipe [SRAM_DELAY];

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // masked bits keep the stored value
  always_ff @(posedge wr_clk) begin
    if (phy_wr.write) begin
      mem[phy_wr.adr] <= (mem[phy_wr.adr] & ~phy_wr.bw) | (phy_wr.din & phy_wr.bw);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // a write on the same edge is not seen, the row is sampled before update
  always_ff @(posedge wr_clk) begin
    if (phy_rd.read) begin
      rd_pipe[0] <= mem[phy_rd.adr];
    end
    for (int s = 1; s < SRAM_DELAY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign rd_data = rd_pipe[SRAM_DELAY-1];

endmodule

/* rtl/mrw_top.sv */
`timescale 1ns/1ns

module mrw_top
  import mrw_pkg::*;
(
  input  logic                    wr_clk,
  input  logic                    rst_n,
  input  wr_cmd_t                 wr_cmd,
  input  rd_cmd_t                 rd_cmd  [NUM_RD_PORTS],
  output logic [NUM_RD_PORTS-1:0] rd_vld,
  output logic [DATA_W-1:0]       rd_dout [NUM_RD_PORTS]
);

  bank_wr_t          bank_wr      [NUM_RD_PORTS][NUM_VBANKS];
  bank_rd_t          bank_rd      [NUM_RD_PORTS][NUM_VBANKS];
  logic [DATA_W-1:0] bank_rd_word [NUM_RD_PORTS][NUM_VBANKS];

  //////////////////////////////////////////////////////////////////////
  // address decode and read steering
  //////////////////////////////////////////////////////////////////////

  mrw_dup_ctrl u_ctrl (
    .wr_clk       (wr_clk),
    .rst_n        (rst_n),
    .wr_cmd       (wr_cmd),
    .rd_cmd       (rd_cmd),
    .bank_wr      (bank_wr),
    .bank_rd      (bank_rd),
    .bank_rd_word (bank_rd_word),
    .rd_vld       (rd_vld),
    .rd_dout      (rd_dout)
  );

  //////////////////////////////////////////////////////////////////////
  // one storage copy per read port
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port
    for (genvar b = 0; b < NUM_VBANKS; b++) begin : g_bank
      phy_wr_t          phy_wr;
      phy_rd_t          phy_rd;
      logic [PHY_W-1:0] rd_data;

      mrw_word_align u_align (
        .wr_clk  (wr_clk),
        .rst_n   (rst_n),
        .bank_wr (bank_wr[p][b]),
        .bank_rd (bank_rd[p][b]),
        .rd_word (bank_rd_word[p][b]),
        .phy_wr  (phy_wr),
        .phy_rd  (phy_rd),
        .rd_data (rd_data)
      );

      mrw_sram_1r1w u_sram (
        .wr_clk  (wr_clk),
        .phy_wr  (phy_wr),
        .phy_rd  (phy_rd),
        .rd_data (rd_data)
      );
    end
  end

endmodule

/* rtl/mrw_word_align.sv */
`timescale 1ns/1ns

module mrw_word_align
  import mrw_pkg::*;
(
  input  logic              wr_clk,
  input  logic              rst_n,
  input  bank_wr_t          bank_wr,
  input  bank_rd_t          bank_rd,
  output logic [DATA_W-1:0] rd_word,
  output phy_wr_t           phy_wr,
  output phy_rd_t           phy_rd,
  input  logic [PHY_W-1:0]  rd_data
);

  logic [WORD_W-1:0] wr_lane;
  logic [WORD_W-1:0] rd_lane;

  // lane of each read in flight, lined up with the sram output
  logic [WORD_W-1:0] lane_pipe [SRAM_DELAY];

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////

  assign wr_lane = bank_wr.row[WORD_W-1:0];

  always_comb begin
    phy_wr.write = bank_wr.write;
    phy_wr.adr   = bank_wr.row[VROW_W-1:WORD_W];
    phy_wr.bw    = '0;
    phy_wr.din   = '0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      // data lands in every lane, the mask picks the one that is written
      phy_wr.din[w*DATA_W +: DATA_W] = bank_wr.din;
      if (wr_lane == WORD_W'(w)) begin
        phy_wr.bw[w*DATA_W +: DATA_W] = bank_wr.bw;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  assign rd_lane = bank_rd.row[WORD_W-1:0];

  always_comb begin
    phy_rd.read = bank_rd.read;
    phy_rd.adr  = bank_rd.row[VROW_W-1:WORD_W];
  end

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      for (int s = 0; s < SRAM_DELAY; s++) begin
        lane_pipe[s] <= '0;
      end
    end else begin
      lane_pipe[0] <= rd_lane;
      for (int s = 1; s < SRAM_DELAY; s++) begin
        lane_pipe[s] <= lane_pipe[s-1];
      end
    end
  end

  // lane select on the returned row
  always_comb begin
    rd_word = rd_data[DATA_W-1:0];
    for (int w = 1; w < NUM_WORDS; w++) begin
      if (lane_pipe[SRAM_DELAY-1] == WORD_W'(w)) begin
        rd_word = rd_data[w*DATA_W +: DATA_W];
      end
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mrw_top -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vtb_mrw_top
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit 1
fi

echo "simulation finished cleanly"
exit 0

/* verif/tb_mrw_tasks.svh */
`ifndef TB_MRW_TASKS_SVH
`define TB_MRW_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// failure reporting and compares
//////////////////////////////////////////////////////////////////////

task automatic abort_run(input string why);
  $display("%s", why);
  $display("Done: errors found");
  $fatal(1, "simulation stopped");
endtask

task automatic check_word(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act,
                          input string name);
  if (act !== exp) begin
    abort_run($sformatf("[ERROR] time %0t %s expected 0x%04h got 0x%04h",
                        $time, name, exp, act));
  end
endtask

task automatic check_vld(input logic [NUM_RD_PORTS-1:0] exp,
                         input logic [NUM_RD_PORTS-1:0] act, input string name);
  if (act !== exp) begin
    abort_run($sformatf("[ERROR] time %0t %s expected %b got %b", $time, name, exp, act));
  end
endtask

//////////////////////////////////////////////////////////////////////
// driving
//////////////////////////////////////////////////////////////////////

task automatic clear_cmds();
  wr_cmd = '0;
  for (int p = 0; p < NUM_RD_PORTS; p++) begin
    rd_cmd[p] = '0;
  end
endtask

task automatic set_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] bw,
                         input logic [DATA_W-1:0] din);
  wr_cmd.write = 1'b1;
  wr_cmd.adr   = adr;
  wr_cmd.bw    = bw;
  wr_cmd.din   = din;
endtask

task automatic set_read(input int p, input logic [ADDR_W-1:0] adr);
  rd_cmd[p].read = 1'b1;
  rd_cmd[p].adr  = adr;
endtask

// reads take the shadow before this cycle's write lands
task automatic advance();
  logic [2:0] slot;
  slot = 3'(cyc + RD_LATENCY);
  for (int p = 0; p < NUM_RD_PORTS; p++) begin
    if (rd_cmd[p].read) begin
      exp_vld[p][slot]  = 1'b1;
      exp_data[p][slot] = shadow[rd_cmd[p].adr];
    end
  end
  if (wr_cmd.write) begin
    shadow[wr_cmd.adr] = (shadow[wr_cmd.adr] & ~wr_cmd.bw) | (wr_cmd.din & wr_cmd.bw);
  end
  @(posedge wr_clk);
  #1;
  clear_cmds();
endtask

function automatic int pending_reads();
  int n;
  n = 0;
  for (int p = 0; p < NUM_RD_PORTS; p++) begin
    for (int s = 0; s < 8; s++) begin
      if (exp_vld[p][s]) n++;
    end
  end
  return n;
endfunction

task automatic wait_idle();
  int n;
  n = 0;
  while (pending_reads() != 0) begin
    if (n == 20) begin
      abort_run("timeout: read results still missing after 20 cycles");
    end
    @(posedge wr_clk);
    #1;
    n++;
  end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset();
  for (int i = 0; i < 5; i++) begin
    advance();
  end
  check_vld('0, rd_vld, "rd_vld");
endtask

task automatic fill_memory();
  logic [ADDR_W-1:0] adr;
  for (int a = 0; a < NUM_ADDR; a++) begin
    adr = ADDR_W'(a);
    set_write(adr, '1, {adr ^ 8'h5a, ~adr});
    advance();
  end
endtask

// steps of 37 walk through every bank and lane
task automatic test_write_read();
  logic [ADDR_W-1:0] adr;
  for (int i = 0; i < 8; i++) begin
    adr = ADDR_W'(i * 37);
    set_write(adr, '1, DATA_W'($urandom));
    advance();
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      set_read(p, adr);
    end
    advance();
  end
  wait_idle();
endtask

task automatic test_bit_mask();
  logic [ADDR_W-1:0] adr;
  logic [ADDR_W-1:0] nbr;
  mrw_adr_u          nbr_u;
  for (int i = 0; i < 2; i++) begin
    adr = (i == 0) ? 8'h34 : 8'h4b;
    // same srow and bank, other lane
    nbr_u.flat   = adr;
    nbr_u.f.word = ~nbr_u.f.word;
    nbr          = nbr_u.flat;
    set_write(adr, '1, 16'h1234);
    advance();
    set_write(nbr, '1, 16'hbeef);
    advance();
    set_write(adr, 16'h0ff0, 16'ha5c3);
    advance();
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      set_read(p, adr);
    end
    advance();
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      set_read(p, nbr);
    end
    advance();
  end
  wait_idle();
endtask

task automatic test_parallel_reads();
  logic [ADDR_W-1:0] base;
  logic [ADDR_W-1:0] step;
  for (int i = 0; i < 20; i++) begin
    base = ADDR_W'($urandom);
    // nonzero step below 128 keeps the port addresses apart
    step = ADDR_W'(1 + ($urandom % 127));
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      set_read(p, base + ADDR_W'(p) * step);
    end
    advance();
  end
  wait_idle();
endtask

task automatic test_same_cycle();
  logic [ADDR_W-1:0] adr;
  adr = 8'h5b;
  set_write(adr, '1, ~shadow[adr]);
  for (int p = 0; p < NUM_RD_PORTS; p++) begin
    set_read(p, adr);
  end
  advance();
  for (int p = 0; p < NUM_RD_PORTS; p++) begin
    set_read(p, adr);
  end
  advance();
  wait_idle();
endtask

task automatic test_random_traffic();
  for (int i = 0; i < 300; i++) begin
    if ($urandom % 2 == 0) begin
      set_write(ADDR_W'($urandom), DATA_W'($urandom), DATA_W'($urandom));
    end
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      if ($urandom % 4 != 0) begin
        set_read(p, ADDR_W'($urandom));
      end
    end
    advance();
  end
  wait_idle();
endtask

`endif

/* verif/tb_mrw_top.sv */
`timescale 1ns/1ns

module tb_mrw_top
  import mrw_pkg::*;
();

  logic                    wr_clk;
  logic                    rst_n;
  wr_cmd_t                 wr_cmd;
  rd_cmd_t                 rd_cmd  [NUM_RD_PORTS];
  logic [NUM_RD_PORTS-1:0] rd_vld;
  logic [DATA_W-1:0]       rd_dout [NUM_RD_PORTS];

  // reference model of the logical memory
  logic [DATA_W-1:0] shadow [NUM_ADDR];

  // expected results per port, indexed by the cycle they are due in
  bit                exp_vld  [NUM_RD_PORTS][8];
  logic [DATA_W-1:0] exp_data [NUM_RD_PORTS][8];

  // counts rising edges since time zero
  int cyc;

  mrw_top dut0 (
    .wr_clk  (wr_clk),
    .rst_n   (rst_n),
    .wr_cmd  (wr_cmd),
    .rd_cmd  (rd_cmd),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  `include "tb_mrw_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // clock and cycle count
  //////////////////////////////////////////////////////////////////////

  initial begin
    wr_clk = 1'b0;
    forever #2 wr_clk = ~wr_clk;
  end

  always @(posedge wr_clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // result checking
  //////////////////////////////////////////////////////////////////////

  // outputs are stable at the falling edge
  always @(negedge wr_clk) begin : result_check
    logic [NUM_RD_PORTS-1:0] exp_v;
    logic [2:0]              slot;
    if (cyc > 0) begin
      slot = 3'(cyc);
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        exp_v[p] = exp_vld[p][slot];
      end
      check_vld(exp_v, rd_vld, "rd_vld");
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        if (exp_v[p]) begin
          check_word(exp_data[p][slot], rd_dout[p], $sformatf("rd_dout[%0d]", p));
        end
        exp_vld[p][slot] = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(66800));
    rst_n = 1'b0;
    clear_cmds();
    repeat (8) @(posedge wr_clk);
    #1;
    rst_n = 1'b1;

    test_reset();
    fill_memory();
    test_write_read();
    test_bit_mask();
    test_parallel_reads();
    test_same_cycle();
    test_random_traffic();

    $display("Done: no errors");
    $finish;
  end

endmodule
